// ==== rtl/hist_pkg.sv ====
//####################
// histogram package
// bin, pixel and window widths, readout FSM states
//####################

package hist_pkg;

    typedef logic [7:0]  pix_t;      // sensor pixel value
    typedef logic [1:0]  color_t;    // bayer color index
    typedef logic [9:0]  bin_addr_t; // {color, pixel} within one bank
    typedef logic [15:0] coord_t;    // window coordinate or size minus one

    localparam int NUM_BINS = 1024; // 4 colors x 256 values
    localparam int ACC_LAT  = 3;    // pixel valid to bin write

    typedef enum logic [1:0] {
        RO_IDLE,   // nothing to send, waits for a finished frame
        RO_STREAM, // issuing bin reads while credits allow
        RO_DONE    // last read issued, draining the read pipe
    } ro_state_t;

endpackage

// ==== rtl/hist_pix_if.sv ====
//####################
// windowed pixel bus, window stage to accumulator
//####################

interface hist_pix_if;

    logic                valid;      // one in-window pixel
    hist_pkg::bin_addr_t addr;       // {color, pixel value}
    logic                bank;       // bank being accumulated
    logic                frame_done; // single cycle, window finished

    modport win_mp (
        output valid,
        output addr,
        output bank,
        output frame_done
    );

    modport acc_mp (
        input valid,
        input addr,
        input bank,
        input frame_done
    );

endinterface

// ==== rtl/hist_window.sv ====
//####################
// frame and window tracker
// finds in-window pixels, bayer color, bank and frame end
//####################

module hist_window #(
    parameter logic [1:0] BAYER_XOR = 2'b00 // line parity in bit 1, column in bit 0
) (
    input  logic             pclk,
    input  logic             hist_rst_pclk,
    input  logic             sof_i,
    input  logic             eof_i,
    input  logic             hact_i,
    input  hist_pkg::pix_t   pix_i,
    input  hist_pkg::coord_t left_i,
    input  hist_pkg::coord_t top_i,
    input  hist_pkg::coord_t width_m1_i,
    input  hist_pkg::coord_t height_m1_i,
    input  logic             hist_en_i,
    input  logic             queue_full_i,
    hist_pix_if.win_mp       pix_o
);

    hist_pkg::coord_t left_q;   // window copy, taken at sof
    hist_pkg::coord_t top_q;
    logic [16:0]      right_q;  // last column, one bit wider against overflow
    logic [16:0]      bottom_q; // last line

    hist_pkg::coord_t line_cnt; // line index from frame start
    hist_pkg::coord_t col_cnt;  // column of the current pixel
    hist_pkg::color_t color;
    logic             hact_d;
    logic             frame_act; // accepted frame, window not finished
    logic             accept;
    logic             line_end;
    logic             in_win;
    logic             done_set;

    assign accept   = sof_i && hist_en_i && !queue_full_i;
    assign line_end = hact_d && !hact_i;

    assign in_win = (line_cnt >= top_q) && ({1'b0, line_cnt} <= bottom_q) &&
                    (col_cnt >= left_q) && ({1'b0, col_cnt} <= right_q);

    // after the last window line, or eof for a window taller than the frame
    assign done_set = frame_act &&
                      (eof_i || (line_end && ({1'b0, line_cnt} == bottom_q)));

    assign color = {line_cnt[0] ^ BAYER_XOR[1], col_cnt[0] ^ BAYER_XOR[0]};

    always_ff @(posedge pclk) begin
        if (accept) begin
            left_q   <= left_i;
            top_q    <= top_i;
            right_q  <= 17'(left_i) + 17'(width_m1_i);
            bottom_q <= 17'(top_i) + 17'(height_m1_i);
        end
        pix_o.addr <= hist_pkg::bin_addr_t'({color, pix_i});
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d           <= 1'b0;
            frame_act        <= 1'b0;
            line_cnt         <= '0;
            col_cnt          <= '0;
            pix_o.valid      <= 1'b0;
            pix_o.frame_done <= 1'b0;
            pix_o.bank       <= 1'b0;
        end else begin
            hact_d  <= hact_i;
            col_cnt <= hact_i ? col_cnt + 16'd1 : '0; // restarts every line

            if (sof_i)         line_cnt <= '0;
            else if (line_end) line_cnt <= line_cnt + 16'd1;

            if (accept)        frame_act <= 1'b1;
            else if (done_set) frame_act <= 1'b0;

            pix_o.valid      <= frame_act && hact_i && in_win;
            pix_o.frame_done <= done_set;

            // toggles the cycle after frame_done
            if (pix_o.frame_done) pix_o.bank <= ~pix_o.bank;
        end
    end

endmodule

// ==== rtl/hist_accum.sv ====
//####################
// bin accumulator
// read, increment with saturation, write back, same-bin forwarding
//####################

module hist_accum #(
    parameter int BIN_W = 20
) (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    hist_pix_if.acc_mp          pix_i,
    input  logic [BIN_W-1:0]    rd_data_i,  // two cycles after rd_addr_o
    output hist_pkg::bin_addr_t rd_addr_o,
    output hist_pkg::bin_addr_t wr_addr_o,
    output logic                bank_o,
    output logic                wr_en_o,
    output logic [BIN_W-1:0]    wr_data_o,
    output logic                acc_done_o
);

    localparam int LAT = hist_pkg::ACC_LAT;

    logic                v1;
    logic                v2;
    logic                v4;  // bin written last cycle
    hist_pkg::bin_addr_t a1;
    hist_pkg::bin_addr_t a2;
    hist_pkg::bin_addr_t a4;
    logic [BIN_W-1:0]    d4;
    logic [BIN_W-1:0]    cur; // freshest count of the bin at stage 2
    logic [BIN_W-1:0]    nxt;
    logic [LAT:1]        bank_d;
    logic [LAT-1:0]      done_d;

    assign rd_addr_o = pix_i.addr; // read issued in the valid cycle

    // bank follows the write stage; reads of a new frame start long after a switch
    assign bank_o = bank_d[LAT];

    assign acc_done_o = done_d[LAT-1]; // pipeline drained by now

    // the memory misses the two newest writes, so take them from the pipe
    always_comb begin
        if (wr_en_o && (wr_addr_o == a2)) begin
            cur = wr_data_o;  // being written this cycle
        end else if (v4 && (a4 == a2)) begin
            cur = d4;         // written one cycle ago
        end else begin
            cur = rd_data_i;
        end
    end

    assign nxt = (&cur) ? cur : cur + BIN_W'(1); // stick at all ones

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            v1      <= 1'b0;
            v2      <= 1'b0;
            wr_en_o <= 1'b0;
            v4      <= 1'b0;
            bank_d  <= '0;
            done_d  <= '0;
        end else begin
            v1      <= pix_i.valid;
            v2      <= v1;
            wr_en_o <= v2;      // ACC_LAT cycles after valid
            v4      <= wr_en_o;
            bank_d  <= {bank_d[LAT-1:1], pix_i.bank};
            done_d  <= {done_d[LAT-2:0], pix_i.frame_done};
        end
    end

    always_ff @(posedge pclk) begin
        a1        <= pix_i.addr;
        a2        <= a1;
        wr_addr_o <= a2;
        a4        <= wr_addr_o;
        wr_data_o <= nxt;
        d4        <= wr_data_o;
    end

endmodule

// ==== rtl/hist_bank_ram.sv ====
//####################
// two-bank bin memory
// accumulate port, read-and-clear readout port, reset sweep
//####################

module hist_bank_ram #(
    parameter int BIN_W = 20
) (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  logic                acc_bank_i,
    input  hist_pkg::bin_addr_t acc_rd_addr_i,
    input  hist_pkg::bin_addr_t acc_wr_addr_i,
    input  logic                acc_wr_en_i,
    input  logic [BIN_W-1:0]    acc_wr_data_i,
    output logic [BIN_W-1:0]    acc_rd_data_o,
    input  logic                ro_bank_i,
    input  hist_pkg::bin_addr_t ro_addr_i,
    input  logic                ro_rd_en_i,
    output logic [BIN_W-1:0]    ro_data_o,
    output logic                busy_o
);

    logic                clr_busy;
    hist_pkg::bin_addr_t clr_addr;   // sweeps both banks at once
    logic                acc_bank_q;
    logic                acc_sel_q;
    hist_pkg::bin_addr_t acc_addr_q;
    logic                ro_en_q;
    logic                ro_bank_q;
    logic                ro_sel_q;
    hist_pkg::bin_addr_t ro_addr_q;

    assign busy_o = clr_busy;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            clr_busy <= 1'b1;
            clr_addr <= '0;
            ro_en_q  <= 1'b0;
        end else begin
            ro_en_q <= ro_rd_en_i;
            if (clr_busy) begin
                clr_addr <= clr_addr + 10'd1;
                if (clr_addr == hist_pkg::bin_addr_t'(hist_pkg::NUM_BINS - 1)) clr_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge pclk) begin
        acc_bank_q <= acc_bank_i;
        acc_addr_q <= acc_rd_addr_i;
        acc_sel_q  <= acc_bank_q;
        ro_bank_q  <= ro_bank_i;
        ro_addr_q  <= ro_addr_i;
        ro_sel_q   <= ro_bank_q;
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [BIN_W-1:0] mem [hist_pkg::NUM_BINS];
        logic [BIN_W-1:0] acc_q;
        logic [BIN_W-1:0] ro_q;

        always_ff @(posedge pclk) begin
            if (clr_busy) begin
                mem[clr_addr] <= '0;
            end else if (ro_en_q && (ro_bank_q == 1'(b))) begin
                mem[ro_addr_q] <= '0;     // old value goes out on ro_q below
            end else if (acc_wr_en_i && (acc_bank_i == 1'(b))) begin
                mem[acc_wr_addr_i] <= acc_wr_data_i;
            end
            acc_q <= mem[acc_addr_q];
            ro_q  <= mem[ro_addr_q];
        end
    end

    assign acc_rd_data_o = acc_sel_q ? g_bank[1].acc_q : g_bank[0].acc_q;
    assign ro_data_o     = ro_sel_q ? g_bank[1].ro_q : g_bank[0].ro_q;

endmodule

// ==== rtl/hist_readout.sv ====
//####################
// readout, one-deep frame queue and credit-counted streaming
//####################

module hist_readout #(
    parameter int BIN_W   = 20,
    parameter int CREDITS = 4
) (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  logic                acc_done_i,
    input  logic                acc_bank_i,   // bank just finished
    input  logic [BIN_W-1:0]    ro_data_i,
    input  logic                credit_i,
    input  logic                busy_i,
    output logic                ro_bank_o,
    output hist_pkg::bin_addr_t ro_addr_o,
    output logic                ro_rd_en_o,
    output logic                queue_full_o,
    output logic [BIN_W-1:0]    hist_data_o,
    output logic                hist_valid_o,
    output logic                hist_last_o
);

    localparam int CRD_W = $clog2(CREDITS + 1);

    hist_pkg::ro_state_t state;
    logic                q_valid;  // finished frame waiting
    logic                q_bank;
    logic [CRD_W-1:0]    credits;
    logic [1:0]          en_d;     // reads in flight
    logic [1:0]          last_d;
    logic                last_addr;
    logic                pop;

    assign last_addr    = (ro_addr_o == hist_pkg::bin_addr_t'(hist_pkg::NUM_BINS - 1));
    assign pop          = (state == hist_pkg::RO_IDLE) && q_valid && !busy_i;
    assign ro_rd_en_o   = (state == hist_pkg::RO_STREAM) && (credits != '0);
    assign queue_full_o = q_valid;
    assign hist_data_o  = ro_data_i;
    assign hist_valid_o = en_d[1];
    assign hist_last_o  = en_d[1] && last_d[1];

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            state     <= hist_pkg::RO_IDLE;
            q_valid   <= 1'b0;
            q_bank    <= 1'b0;
            ro_bank_o <= 1'b0;
            ro_addr_o <= '0;
            credits   <= CRD_W'(CREDITS);
            en_d      <= '0;
            last_d    <= '0;
        end else begin
            en_d    <= {en_d[0], ro_rd_en_o};
            last_d  <= {last_d[0], last_addr};
            credits <= credits - CRD_W'(ro_rd_en_o) + CRD_W'(credit_i); // word out, credit back

            // a push in the pop cycle refills the queue
            if (acc_done_i) begin
                q_valid <= 1'b1;
                q_bank  <= acc_bank_i;
            end else if (pop) begin
                q_valid <= 1'b0;
            end

            case (state)
                hist_pkg::RO_IDLE: begin
                    if (pop) begin
                        state     <= hist_pkg::RO_STREAM;
                        ro_bank_o <= q_bank;
                        ro_addr_o <= '0;
                    end
                end
                hist_pkg::RO_STREAM: begin
                    if (ro_rd_en_o) begin              // holds address without credits
                        ro_addr_o <= ro_addr_o + 10'd1;
                        if (last_addr) state <= hist_pkg::RO_DONE;
                    end
                end
                hist_pkg::RO_DONE: begin
                    if (en_d == 2'b00) state <= hist_pkg::RO_IDLE; // last word sent
                end
                default: state <= hist_pkg::RO_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/hist_top.sv ====
//####################
// histogram top level
// window, accumulator, bin memory and readout
//####################

module hist_top #(
    parameter int         BIN_W     = 20,
    parameter int         CREDITS   = 4,
    parameter logic [1:0] BAYER_XOR = 2'b00
) (
    input  logic             pclk,
    input  logic             hist_rst_pclk,
    input  logic             sof_i,
    input  logic             eof_i,
    input  logic             hact_i,
    input  hist_pkg::pix_t   pix_i,
    input  hist_pkg::coord_t left_i,
    input  hist_pkg::coord_t top_i,
    input  hist_pkg::coord_t width_m1_i,
    input  hist_pkg::coord_t height_m1_i,
    input  logic             hist_en_i,
    input  logic             hist_credit_i,
    output logic [BIN_W-1:0] hist_data_o,
    output logic             hist_valid_o,
    output logic             hist_last_o,
    output logic             hist_busy_o
);

    hist_pkg::bin_addr_t acc_rd_addr;
    hist_pkg::bin_addr_t acc_wr_addr;
    logic                acc_bank;
    logic                acc_wr_en;
    logic [BIN_W-1:0]    acc_wr_data;
    logic [BIN_W-1:0]    acc_rd_data;
    logic                acc_done;
    logic                ro_bank;
    hist_pkg::bin_addr_t ro_addr;
    logic                ro_rd_en;
    logic [BIN_W-1:0]    ro_data;
    logic                queue_full;

    hist_pix_if pix_if ();

    hist_window #(
        .BAYER_XOR (BAYER_XOR)
    ) u_window (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sof_i         (sof_i),
        .eof_i         (eof_i),
        .hact_i        (hact_i),
        .pix_i         (pix_i),
        .left_i        (left_i),
        .top_i         (top_i),
        .width_m1_i    (width_m1_i),
        .height_m1_i   (height_m1_i),
        .hist_en_i     (hist_en_i),
        .queue_full_i  (queue_full),
        .pix_o         (pix_if.win_mp)
    );

    hist_accum #(
        .BIN_W (BIN_W)
    ) u_accum (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_i         (pix_if.acc_mp),
        .rd_data_i     (acc_rd_data),
        .rd_addr_o     (acc_rd_addr),
        .wr_addr_o     (acc_wr_addr),
        .bank_o        (acc_bank),
        .wr_en_o       (acc_wr_en),
        .wr_data_o     (acc_wr_data),
        .acc_done_o    (acc_done)
    );

    hist_bank_ram #(
        .BIN_W (BIN_W)
    ) u_bank_ram (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .acc_bank_i    (acc_bank),
        .acc_rd_addr_i (acc_rd_addr),
        .acc_wr_addr_i (acc_wr_addr),
        .acc_wr_en_i   (acc_wr_en),
        .acc_wr_data_i (acc_wr_data),
        .acc_rd_data_o (acc_rd_data),
        .ro_bank_i     (ro_bank),
        .ro_addr_i     (ro_addr),
        .ro_rd_en_i    (ro_rd_en),
        .ro_data_o     (ro_data),
        .busy_o        (hist_busy_o)
    );

    hist_readout #(
        .BIN_W   (BIN_W),
        .CREDITS (CREDITS)
    ) u_readout (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .acc_done_i    (acc_done),
        .acc_bank_i    (acc_bank),
        .ro_data_i     (ro_data),
        .credit_i      (hist_credit_i),
        .busy_i        (hist_busy_o),
        .ro_bank_o     (ro_bank),
        .ro_addr_o     (ro_addr),
        .ro_rd_en_o    (ro_rd_en),
        .queue_full_o  (queue_full),
        .hist_data_o   (hist_data_o),
        .hist_valid_o  (hist_valid_o),
        .hist_last_o   (hist_last_o)
    );

endmodule

// ==== verif/hist_checker.sv ====
//####################
// output stream checker
// expected bin queue, word compare, credit accounting
//####################

module hist_checker #(
    parameter int BIN_W   = 20,
    parameter int CREDITS = 4
) (
    input  logic             pclk,
    input  logic             hist_rst_pclk,
    input  logic [BIN_W-1:0] hist_data_i,
    input  logic             hist_valid_i,
    input  logic             hist_last_i,
    input  logic             hist_credit_i,
    output int               word_cnt_o,
    output int               err_cnt_o,
    output int               pend_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [BIN_W-1:0] exp_q[$]; // expected bins in stream order
    int               outstanding;

    initial begin
        word_cnt_o  = 0;
        err_cnt_o   = 0;
        pend_o      = 0;
        outstanding = 0;
    end

    // called by the testbench for every bin of an accepted frame
    task automatic push_expected(input logic [BIN_W-1:0] value);
        exp_q.push_back(value);
        pend_o = exp_q.size();
    endtask

    always @(posedge pclk) begin
        int               bin;
        logic [BIN_W-1:0] exp_val;
        logic             exp_last;
        if (!hist_rst_pclk) begin
            outstanding = outstanding + int'(hist_valid_i) - int'(hist_credit_i);
            if (outstanding > CREDITS) begin
                $display("outstanding words %0d exceed the %0d credits", outstanding, CREDITS);
                err_cnt_o++;
            end
            if (hist_last_i && !hist_valid_i) begin
                $display("hist_last_o high without hist_valid_o");
                err_cnt_o++;
            end
            if (hist_valid_i) begin
                bin = word_cnt_o % hist_pkg::NUM_BINS;
                if (exp_q.size() == 0) begin
                    $display("unexpected word on the output, no frame pending");
                    err_cnt_o++;
                end else begin
                    exp_val  = exp_q.pop_front();
                    exp_last = (bin == hist_pkg::NUM_BINS - 1);
                    if (hist_data_i !== exp_val) begin
                        $display("** Error: hist_data_o bin %03h got %h exp %h",
                                 bin, hist_data_i, exp_val);
                        err_cnt_o++;
                    end
                    if (hist_last_i !== exp_last) begin
                        $display("** Error: hist_last_o bin %03h got %h exp %h",
                                 bin, hist_last_i, exp_last);
                        err_cnt_o++;
                    end
                end
                word_cnt_o++;
                pend_o = exp_q.size();
            end
        end
    end

endmodule

// ==== verif/hist_tb.sv ====
//####################
// histogram testbench
// clock, reset, frames, credit return, reference histogram
//####################

module hist_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int         BIN_W     = 20;
    localparam int         CREDITS   = 4;
    localparam logic [1:0] BAYER_XOR = 2'b01;
    localparam int         FR_W      = 32; // frame size in pixels
    localparam int         FR_H      = 16;

    logic             pclk = 1'b0;
    logic             hist_rst_pclk;
    logic             sof_i;
    logic             eof_i;
    logic             hact_i;
    logic             hist_en_i;
    logic             hist_credit_i;
    hist_pkg::pix_t   pix_i;
    hist_pkg::coord_t left_i;
    hist_pkg::coord_t top_i;
    hist_pkg::coord_t width_m1_i;
    hist_pkg::coord_t height_m1_i;
    logic [BIN_W-1:0] hist_data_o;
    logic             hist_valid_o;
    logic             hist_last_o;
    logic             hist_busy_o;

    hist_pkg::pix_t   pix_mem [FR_W*FR_H];
    logic [BIN_W-1:0] exp_bins [hist_pkg::NUM_BINS];
    int               seed = 32'hbcbf;
    int               credit_mode; // 0 withheld, 1 every cycle, 2 sporadic
    int               owed;
    int               timeouts;
    int               busy_errs;   // clear sweep flag errors
    int               target;
    int               word_cnt;
    int               err_cnt;
    int               pend;

    hist_top #(.BIN_W(BIN_W), .CREDITS(CREDITS), .BAYER_XOR(BAYER_XOR)) UUT (
        .pclk(pclk), .hist_rst_pclk(hist_rst_pclk), .sof_i(sof_i), .eof_i(eof_i),
        .hact_i(hact_i), .pix_i(pix_i), .left_i(left_i), .top_i(top_i),
        .width_m1_i(width_m1_i), .height_m1_i(height_m1_i), .hist_en_i(hist_en_i),
        .hist_credit_i(hist_credit_i), .hist_data_o(hist_data_o),
        .hist_valid_o(hist_valid_o), .hist_last_o(hist_last_o), .hist_busy_o(hist_busy_o)
    );

    hist_checker #(.BIN_W(BIN_W), .CREDITS(CREDITS)) u_checker (
        .pclk(pclk), .hist_rst_pclk(hist_rst_pclk), .hist_data_i(hist_data_o),
        .hist_valid_i(hist_valid_o), .hist_last_i(hist_last_o),
        .hist_credit_i(hist_credit_i), .word_cnt_o(word_cnt), .err_cnt_o(err_cnt),
        .pend_o(pend)
    );

    always #20 pclk = ~pclk;

    // consumer, gives back one credit per received word
    initial begin
        int cyc;
        hist_credit_i = 1'b0;
        owed          = 0;
        cyc           = 0;
        forever begin
            @(posedge pclk);
            if (hist_valid_o) owed++;
            cyc++;
            #2;
            hist_credit_i = 1'b0;
            if (owed > 0 && (credit_mode == 1 || (credit_mode == 2 && cyc % 7 == 3))) begin
                hist_credit_i = 1'b1;
                owed--;
            end
        end
    end

    // expected bins from pixel array, window and bayer rules
    function automatic void ref_hist(input int left, input int top, input int wm1,
                                     input int hm1);
        hist_pkg::color_t c;
        int               idx;
        for (int b = 0; b < hist_pkg::NUM_BINS; b++) exp_bins[b] = '0;
        for (int ln = 0; ln < FR_H; ln++) begin
            for (int cl = 0; cl < FR_W; cl++) begin
                if (ln >= top && ln <= top + hm1 && cl >= left && cl <= left + wm1) begin
                    c   = {ln[0] ^ BAYER_XOR[1], cl[0] ^ BAYER_XOR[0]};
                    idx = int'(c) * 256 + int'(pix_mem[ln*FR_W + cl]);
                    if (~exp_bins[idx] != '0) exp_bins[idx] = exp_bins[idx] + BIN_W'(1);
                end
            end
        end
    endfunction

    task automatic fill_pixels(input bit rand_en, input hist_pkg::pix_t value);
        for (int i = 0; i < FR_W*FR_H; i++) begin
            pix_mem[i] = rand_en ? hist_pkg::pix_t'($random(seed)) : value;
        end
    endtask

    task automatic next_cycle();
        @(posedge pclk);
        #2;
    endtask

    // one frame on the sensor inputs, expected bins queued if it should be accepted
    task automatic run_frame(input int left, input int top, input int wm1, input int hm1,
                             input bit accepted);
        left_i      = hist_pkg::coord_t'(left);
        top_i       = hist_pkg::coord_t'(top);
        width_m1_i  = hist_pkg::coord_t'(wm1);
        height_m1_i = hist_pkg::coord_t'(hm1);
        ref_hist(left, top, wm1, hm1);
        if (accepted) begin
            for (int b = 0; b < hist_pkg::NUM_BINS; b++) u_checker.push_expected(exp_bins[b]);
        end
        sof_i = 1'b1;
        next_cycle();
        sof_i = 1'b0;
        next_cycle();
        for (int ln = 0; ln < FR_H; ln++) begin
            for (int cl = 0; cl < FR_W; cl++) begin
                hact_i = 1'b1;
                pix_i  = pix_mem[ln*FR_W + cl];
                next_cycle();
            end
            hact_i = 1'b0;
            repeat (4) next_cycle(); // line blanking
        end
        eof_i = 1'b1;
        next_cycle();
        eof_i = 1'b0;
        repeat (12) next_cycle();
    endtask

    task automatic wait_words(input int count, input int limit);
        int cyc;
        cyc = 0;
        while (word_cnt < count && cyc < limit) begin
            next_cycle();
            cyc++;
        end
        if (word_cnt < count) begin
            $display("timeout: %0d of %0d histogram words received", word_cnt, count);
            timeouts++;
        end
    endtask

    // busy high from reset for one cycle per bin
    task automatic wait_ready(input int limit);
        int cyc;
        cyc = 0;
        if (hist_busy_o !== 1'b1) begin
            $display("** Error: hist_busy_o after reset got %h exp %h", hist_busy_o, 1'b1);
            busy_errs++;
        end
        while (hist_busy_o && cyc < limit) begin
            next_cycle();
            cyc++;
        end
        if (hist_busy_o) begin
            $display("timeout: bin memory clear sweep never finished");
            timeouts++;
        end else if (cyc != hist_pkg::NUM_BINS) begin
            $display("** Error: hist_busy_o sweep cycles got %h exp %h",
                     cyc, hist_pkg::NUM_BINS);
            busy_errs++;
        end
    endtask

    initial begin
        hist_rst_pclk = 1'b1;
        {sof_i, eof_i, hact_i} = 3'b000;
        pix_i       = '0;
        left_i      = '0;
        top_i       = '0;
        width_m1_i  = '0;
        height_m1_i = '0;
        hist_en_i   = 1'b1;
        credit_mode = 1;
        timeouts    = 0;
        busy_errs   = 0;
        target      = 0;
        repeat (2) @(posedge pclk);
        #2;
        hist_rst_pclk = 1'b0;
        wait_ready(1100);

        // full window, then offset window while the first one streams
        fill_pixels(1'b1, 8'h00);
        run_frame(0, 0, FR_W - 1, FR_H - 1, 1'b1);
        fill_pixels(1'b1, 8'h00);
        run_frame(5, 3, 9, 5, 1'b1);
        target += hist_pkg::NUM_BINS + 1; // second frame streaming and out of the queue
        wait_words(target, 20000);

        // one repeated value
        fill_pixels(1'b0, 8'h5a);
        run_frame(3, 2, 20, 10, 1'b1);
        target += 2 * hist_pkg::NUM_BINS - 1;
        wait_words(target, 20000);

        // sporadic credits
        credit_mode = 2;
        fill_pixels(1'b1, 8'h00);
        run_frame(1, 1, 27, 13, 1'b1);
        target += hist_pkg::NUM_BINS;
        wait_words(target, 20000);

        // credits withheld, the third frame finds the queue full
        credit_mode = 0;
        fill_pixels(1'b1, 8'h00);
        run_frame(0, 0, FR_W - 1, FR_H - 1, 1'b1);
        fill_pixels(1'b0, 8'h11);
        run_frame(2, 4, 12, 8, 1'b1);
        fill_pixels(1'b1, 8'h00);
        run_frame(0, 0, FR_W - 1, FR_H - 1, 1'b0);
        credit_mode = 1;
        target += 2 * hist_pkg::NUM_BINS;
        wait_words(target, 20000);

        repeat (100) next_cycle();
        if (pend != 0) begin
            $display("%0d expected bins were never received", pend);
            timeouts++;
        end
        $display("words %0d, errors %0d, timeouts %0d", word_cnt, err_cnt + busy_errs,
                 timeouts);
        if (err_cnt == 0 && busy_errs == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/hist_pkg.sv
rtl/hist_pix_if.sv
rtl/hist_window.sv
rtl/hist_accum.sv
rtl/hist_bank_ram.sv
rtl/hist_readout.sv
rtl/hist_top.sv
verif/hist_checker.sv
verif/hist_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module hist_tb --Mdir obj_dir -o hist_sim

out=$(./obj_dir/hist_sim)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
